//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := dcacheTb
FILELIST  := vlog.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- design/dcache.sv
// two-way write-back data cache; datapath holds ren/wen until hit, halt is a held level
`timescale 1ns/1ps

module dcache
#(
        parameter int indexBits = 3,
        localparam int tagBits = $bits(dcachePkg::addrT) - indexBits
                - dcachePkg::blockOffBits - dcachePkg::byteOffBits
)
(
        input logic clk,
        input logic rstN,
        input dcachePkg::cpuReqT cpuReq,
        output dcachePkg::cpuRspT cpuRsp,
        output dcachePkg::memReqT memReq,
        input dcachePkg::memRspT memRsp
);

        logic tagHit;
        logic hitWay;
        logic victimWay;
        logic victimValid;
        logic victimDirty;
        logic [tagBits-1:0] victimTag;
        logic flushDirty;
        logic [tagBits-1:0] flushTag;
        logic fill;
        logic fillWay;
        logic storeHit;
        logic touch;
        logic clean;
        logic [indexBits-1:0] flushSet;
        logic flushWay;
        logic dataWrEn;
        logic dataWrWay;
        logic dataWrWord;
        dcachePkg::wordT dataWrData;
        logic [indexBits-1:0] altSet;
        logic altWay;
        logic altWord;
        dcachePkg::wordT altData;
        dcachePkg::wordT rdData;
        logic hit;
        logic flushed;

        dcacheTagArray #(.indexBits(indexBits)) tagArray_i (
                .clk(clk), .rstN(rstN), .addr(cpuReq.addr),
                .fill(fill), .fillWay(fillWay), .storeHit(storeHit), .touch(touch),
                .clean(clean), .flushSet(flushSet), .flushWay(flushWay),
                .hit(tagHit), .hitWay(hitWay), .victimWay(victimWay),
                .victimValid(victimValid), .victimDirty(victimDirty), .victimTag(victimTag),
                .flushDirty(flushDirty), .flushTag(flushTag)
        );

        dcacheDataArray #(.indexBits(indexBits)) dataArray_i (
                .clk(clk), .rstN(rstN), .addr(cpuReq.addr),
                .wrEn(dataWrEn), .wrWay(dataWrWay), .wrWord(dataWrWord), .wrData(dataWrData),
                .rdWay(hitWay), .rdData(rdData),
                .altSet(altSet), .altWay(altWay), .altWord(altWord), .altData(altData)
        );

        dcacheController #(.indexBits(indexBits)) controller_i (
                .clk(clk), .rstN(rstN), .cpuReq(cpuReq), .tagHit(tagHit),
                .victimWay(victimWay), .victimValid(victimValid), .victimDirty(victimDirty),
                .victimTag(victimTag), .flushDirty(flushDirty), .flushTag(flushTag),
                .altData(altData), .memRsp(memRsp), .memReq(memReq),
                .hit(hit), .flushed(flushed), .fill(fill), .fillWay(fillWay),
                .storeHit(storeHit), .touch(touch), .clean(clean),
                .flushSet(flushSet), .flushWay(flushWay),
                .dataWrEn(dataWrEn), .dataWrWay(dataWrWay), .dataWrWord(dataWrWord),
                .dataWrData(dataWrData), .altSet(altSet), .altWay(altWay), .altWord(altWord)
        );

        assign cpuRsp.hit = hit;
        assign cpuRsp.load = rdData;
        assign cpuRsp.flushed = flushed;

endmodule

//--- design/dcacheController.sv
// one access in flight; request and memory inputs must hold stable until hit or waitMem low
`timescale 1ns/1ps

module dcacheController
#(
        parameter int indexBits = 3,
        localparam int tagBits = $bits(dcachePkg::addrT) - indexBits
                - dcachePkg::blockOffBits - dcachePkg::byteOffBits
)
(
        input logic clk,
        input logic rstN,
        input dcachePkg::cpuReqT cpuReq,
        input logic tagHit,
        input logic victimWay,
        input logic victimValid,
        input logic victimDirty,
        input logic [tagBits-1:0] victimTag,
        input logic flushDirty,
        input logic [tagBits-1:0] flushTag,
        input dcachePkg::wordT altData,
        input dcachePkg::memRspT memRsp,
        output dcachePkg::memReqT memReq,
        output logic hit,
        output logic flushed,
        output logic fill,
        output logic fillWay,
        output logic storeHit,
        output logic touch,
        output logic clean,
        output logic [indexBits-1:0] flushSet,
        output logic flushWay,
        output logic dataWrEn,
        output logic dataWrWay,
        output logic dataWrWord,
        output dcachePkg::wordT dataWrData,
        output logic [indexBits-1:0] altSet,
        output logic altWay,
        output logic altWord
);

        localparam int setLsb = dcachePkg::byteOffBits + dcachePkg::blockOffBits;
        localparam logic [dcachePkg::byteOffBits-1:0] byteZero = '0;

        typedef logic [indexBits-1:0] indexT;

        dcachePkg::ctrlStateT stateQ;
        dcachePkg::ctrlStateT stateD;
        indexT flushSetQ;
        logic flushWayQ;

        indexT reqSet;
        logic [tagBits+indexBits-1:0] reqBlock;
        logic access;
        logic flushing;
        logic lastLine;

        assign reqSet = cpuReq.addr[setLsb +: indexBits];
        assign reqBlock = cpuReq.addr[$bits(dcachePkg::addrT)-1:setLsb];
        assign access = cpuReq.ren || cpuReq.wen;
        assign flushing = (stateQ == dcachePkg::FLUSH0) || (stateQ == dcachePkg::FLUSH1)
                || (stateQ == dcachePkg::FLUSHNEXT);
        assign lastLine = (flushSetQ == '1) && flushWayQ;

        always_comb
        begin
                stateD = stateQ;
                case (stateQ)
                dcachePkg::IDLE:
                begin
                        // a pending access wins over halt
                        if (access)
                        begin
                                if (!tagHit)
                                        stateD = (victimValid && victimDirty) ?
                                                dcachePkg::WB0 : dcachePkg::FETCH0;
                        end
                        else if (cpuReq.halt)
                                stateD = dcachePkg::FLUSHNEXT;
                end
                dcachePkg::WB0:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::WB1;
                dcachePkg::WB1:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::FETCH0;
                dcachePkg::FETCH0:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::FETCH1;
                dcachePkg::FETCH1:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::IDLE;
                dcachePkg::FLUSHNEXT:
                begin
                        if (flushDirty)
                                stateD = dcachePkg::FLUSH0;
                        else if (lastLine)
                                stateD = dcachePkg::DONE;
                end
                dcachePkg::FLUSH0:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::FLUSH1;
                dcachePkg::FLUSH1:
                        if (!memRsp.waitMem)
                                stateD = dcachePkg::FLUSHNEXT;
                dcachePkg::DONE:
                        stateD = dcachePkg::DONE;
                default:
                        stateD = dcachePkg::IDLE;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (!rstN)
                begin
                        stateQ <= dcachePkg::IDLE;
                        flushSetQ <= '0;
                        flushWayQ <= 1'b0;
                end
                else
                begin
                        stateQ <= stateD;
                        // way 0 then way 1, then the next set
                        if (stateQ == dcachePkg::FLUSHNEXT && !flushDirty && !lastLine)
                                {flushSetQ, flushWayQ} <= {flushSetQ, flushWayQ} + 1'b1;
                end
        end

        assign altSet = flushing ? flushSetQ : reqSet;
        assign altWay = flushing ? flushWayQ : victimWay;
        assign altWord = (stateQ == dcachePkg::WB1) || (stateQ == dcachePkg::FLUSH1);

        assign flushSet = flushSetQ;
        assign flushWay = flushWayQ;
        assign fillWay = victimWay;
        assign dataWrWay = victimWay;
        assign flushed = (stateQ == dcachePkg::DONE);

        always_comb
        begin
                memReq = '0;
                memReq.store = altData;
                hit = 1'b0;
                touch = 1'b0;
                storeHit = 1'b0;
                fill = 1'b0;
                clean = 1'b0;
                dataWrEn = 1'b0;
                dataWrWord = cpuReq.addr[dcachePkg::byteOffBits];
                dataWrData = cpuReq.store;
                case (stateQ)
                dcachePkg::IDLE:
                begin
                        hit = access && tagHit;
                        touch = hit;
                        storeHit = hit && cpuReq.wen;
                        dataWrEn = storeHit;
                end
                dcachePkg::WB0, dcachePkg::WB1:
                begin
                        memReq.wen = 1'b1;
                        memReq.addr = {victimTag, reqSet, altWord, byteZero};
                end
                dcachePkg::FETCH0, dcachePkg::FETCH1:
                begin
                        memReq.ren = 1'b1;
                        memReq.addr = {reqBlock, stateQ == dcachePkg::FETCH1, byteZero};
                        dataWrEn = !memRsp.waitMem;
                        dataWrWord = (stateQ == dcachePkg::FETCH1);
                        dataWrData = memRsp.load;
                        // line turns valid with its second word
                        fill = !memRsp.waitMem && (stateQ == dcachePkg::FETCH1);
                end
                dcachePkg::FLUSH0, dcachePkg::FLUSH1:
                begin
                        memReq.wen = 1'b1;
                        memReq.addr = {flushTag, flushSetQ, altWord, byteZero};
                        clean = !memRsp.waitMem && (stateQ == dcachePkg::FLUSH1);
                end
                default:
                begin
                        memReq.wen = 1'b0;
                end
                endcase
        end

endmodule

//--- design/dcacheDataArray.sv
// two words per way per set, no reset on contents; writes are ignored while reset is held
`timescale 1ns/1ps

module dcacheDataArray
#(
        parameter int indexBits = 3
)
(
        input logic clk,
        input logic rstN,
        input dcachePkg::addrT addr,
        input logic wrEn,
        input logic wrWay,
        input logic wrWord,
        input dcachePkg::wordT wrData,
        input logic rdWay,
        output dcachePkg::wordT rdData,
        input logic [indexBits-1:0] altSet,
        input logic altWay,
        input logic altWord,
        output dcachePkg::wordT altData
);

        localparam int numSets = 1 << indexBits;
        localparam int setLsb = dcachePkg::byteOffBits + dcachePkg::blockOffBits;

        typedef logic [indexBits-1:0] indexT;

        dcachePkg::wordT dataQ [numSets][2][2];

        indexT set;
        logic word;

        assign set = addr[setLsb +: indexBits];
        assign word = addr[dcachePkg::byteOffBits];

        // store hits and fills both land in the request's set
        always_ff @(posedge clk)
        begin
                if (rstN && wrEn)
                        dataQ[set][wrWay][wrWord] <= wrData;
        end

        assign rdData = dataQ[set][rdWay][word];

        // write-back source for victim or flush line
        assign altData = dataQ[altSet][altWay][altWord];

endmodule

//--- design/dcachePkg.sv
// cache types shared by the design; byte addresses, 32-bit words, blocks of exactly two words
package dcachePkg;

        typedef logic [31:0] wordT;
        typedef logic [31:0] addrT;

        // byte select inside a word
        localparam int byteOffBits = 2;
        // word select inside a block
        localparam int blockOffBits = 1;

        typedef struct packed
        {
                logic ren;
                logic wen;
                logic halt;
                addrT addr;
                wordT store;
        } cpuReqT;

        typedef struct packed
        {
                logic hit;
                wordT load;
                logic flushed;
        } cpuRspT;

        typedef struct packed
        {
                logic ren;
                logic wen;
                addrT addr;
                wordT store;
        } memReqT;

        typedef struct packed
        {
                logic waitMem;
                wordT load;
        } memRspT;

        typedef enum logic [3:0]
        {
                IDLE, WB0, WB1, FETCH0, FETCH1, FLUSH0, FLUSH1, FLUSHNEXT, DONE
        } ctrlStateT;

endpackage

//--- design/dcacheTagArray.sv
// two ways per set, one LRU bit per set; on a hit the victim outputs follow the hit way
`timescale 1ns/1ps

module dcacheTagArray
#(
        parameter int indexBits = 3,
        localparam int tagBits = $bits(dcachePkg::addrT) - indexBits
                - dcachePkg::blockOffBits - dcachePkg::byteOffBits
)
(
        input logic clk,
        input logic rstN,
        input dcachePkg::addrT addr,
        input logic fill,
        input logic fillWay,
        input logic storeHit,
        input logic touch,
        input logic clean,
        input logic [indexBits-1:0] flushSet,
        input logic flushWay,
        output logic hit,
        output logic hitWay,
        output logic victimWay,
        output logic victimValid,
        output logic victimDirty,
        output logic [tagBits-1:0] victimTag,
        output logic flushDirty,
        output logic [tagBits-1:0] flushTag
);

        localparam int numSets = 1 << indexBits;
        localparam int setLsb = dcachePkg::byteOffBits + dcachePkg::blockOffBits;

        typedef logic [tagBits-1:0] tagT;
        typedef logic [indexBits-1:0] indexT;

        tagT tagQ [numSets][2];
        logic [numSets-1:0][1:0] validQ;
        logic [numSets-1:0][1:0] dirtyQ;
        logic [numSets-1:0] lruQ;

        indexT set;
        tagT tag;
        logic [1:0] wayHit;

        assign set = addr[setLsb +: indexBits];
        assign tag = addr[$bits(dcachePkg::addrT)-1 -: tagBits];

        assign wayHit[0] = validQ[set][0] && (tagQ[set][0] == tag);
        assign wayHit[1] = validQ[set][1] && (tagQ[set][1] == tag);
        assign hit = |wayHit;
        assign hitWay = wayHit[1];

        // invalid way first, else the LRU way
        always_comb
        begin
                if (hit)
                        victimWay = hitWay;
                else if (!validQ[set][0])
                        victimWay = 1'b0;
                else if (!validQ[set][1])
                        victimWay = 1'b1;
                else
                        victimWay = lruQ[set];
        end

        assign victimValid = validQ[set][victimWay];
        assign victimDirty = dirtyQ[set][victimWay];
        assign victimTag = tagQ[set][victimWay];

        assign flushDirty = validQ[flushSet][flushWay] && dirtyQ[flushSet][flushWay];
        assign flushTag = tagQ[flushSet][flushWay];

        always_ff @(posedge clk)
        begin
                if (fill)
                        tagQ[set][fillWay] <= tag;
        end

        always_ff @(posedge clk)
        begin
                if (!rstN)
                begin
                        validQ <= '0;
                        dirtyQ <= '0;
                        lruQ <= '0;
                end
                else
                begin
                        // a freshly fetched block is clean
                        if (fill)
                        begin
                                validQ[set][fillWay] <= 1'b1;
                                dirtyQ[set][fillWay] <= 1'b0;
                        end
                        if (storeHit)
                                dirtyQ[set][hitWay] <= 1'b1;
                        if (clean)
                                dirtyQ[flushSet][flushWay] <= 1'b0;
                        // other way becomes least recently used
                        if (touch)
                                lruQ[set] <= ~hitWay;
                end
        end

endmodule

//--- test/dcacheTb.sv
// built for indexBits 3 (tag addr[31:6], set addr[5:3], word addr[2]); memory stalls 0 to 3 cycles
`timescale 1ns/1ps

module dcacheTb;

        localparam dcachePkg::addrT addrA = 32'h0000_1010;
        localparam dcachePkg::addrT addrB = 32'h0000_2010;
        localparam dcachePkg::addrT addrC = 32'h0000_3010;
        localparam dcachePkg::addrT addrD = 32'h0000_4028;

        logic clk;
        logic rstN;
        dcachePkg::cpuReqT cpuReq;
        dcachePkg::cpuRspT cpuRsp;
        dcachePkg::memReqT memReq;
        dcachePkg::memRspT memRsp;

        // what the DUT wrote to memory, and what the datapath stored
        dcachePkg::wordT memImg [dcachePkg::addrT];
        dcachePkg::wordT refImg [dcachePkg::addrT];
        dcachePkg::memReqT xferLog [$];
        integer seed = 32'hec88;
        int waitLeft = 0;

        dcache #(.indexBits(3)) dut_i (
                .clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuRsp(cpuRsp),
                .memReq(memReq), .memRsp(memRsp)
        );

        bind dcache dcacheSva sva_i (.clk(clk), .rstN(rstN), .cpuRsp(cpuRsp), .memReq(memReq));

        initial
        begin
                clk = 1'b0;
                forever
                        #2 clk = ~clk;
        end

        // unwritten words hold a pattern of their own address
        function automatic dcachePkg::wordT fillWord(input dcachePkg::addrT a);
                return a ^ 32'h5ca1_ab1e;
        endfunction

        function automatic dcachePkg::wordT memWord(input dcachePkg::addrT a);
                return memImg.exists(a) ? memImg[a] : fillWord(a);
        endfunction

        function automatic dcachePkg::wordT refWord(input dcachePkg::addrT a);
                return refImg.exists(a) ? refImg[a] : fillWord(a);
        endfunction

        task automatic stopRun();
                $display("TEST FAILED");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic checkValue(input string name, input logic [31:0] expected,
                input logic [31:0] actual);
                assert (actual === expected)
                else
                begin
                        $display("ERR %s expected %h actual %h", name, expected, actual);
                        stopRun();
                end
        endtask

        task automatic checkXfer(input string name, input int idx, input logic wen,
                input dcachePkg::addrT a, input dcachePkg::wordT d);
                checkValue($sformatf("%s xfer%0d op", name, idx), wen, xferLog[idx].wen);
                checkValue($sformatf("%s xfer%0d addr", name, idx), a, xferLog[idx].addr);
                if (wen)
                        checkValue($sformatf("%s xfer%0d data", name, idx), d,
                                xferLog[idx].store);
        endtask

        // one load or store held until hit; xfers counts the expected memory words
        task automatic access(input string name, input logic wr, input dcachePkg::addrT a,
                input dcachePkg::wordT d, input int xfers);
                int cycles;
                @(posedge clk);
                #1;
                xferLog.delete();
                cpuReq.ren = !wr;
                cpuReq.wen = wr;
                cpuReq.addr = a;
                cpuReq.store = d;
                cycles = 0;
                @(negedge clk);
                while (!cpuRsp.hit)
                begin
                        cycles++;
                        if (cycles > 60)
                        begin
                                $display("no hit within 60 cycles for %s", name);
                                stopRun();
                        end
                        @(negedge clk);
                end
                if (!wr)
                        checkValue({name, " load"}, refWord(a), cpuRsp.load);
                else
                        refImg[a] = d;
                checkValue({name, " memory words"}, xfers, xferLog.size());
                @(posedge clk);
                #1;
                cpuReq.ren = 1'b0;
                cpuReq.wen = 1'b0;
        endtask

        task automatic waitFlushed();
                int cycles;
                cycles = 0;
                @(negedge clk);
                while (!cpuRsp.flushed)
                begin
                        cycles++;
                        if (cycles > 200)
                        begin
                                $display("flushed did not rise within 200 cycles of halt");
                                stopRun();
                        end
                        @(negedge clk);
                end
        endtask

        always @(negedge clk)
        begin
                if (dut_i.sva_i.failCount != 0)
                begin
                        $display("a protocol assertion on the cache top level failed");
                        stopRun();
                end
        end

        // memory model completes a word at the edge where waitMem is low
        always @(posedge clk)
        begin
                if (rstN && !memRsp.waitMem && (memReq.ren || memReq.wen))
                begin
                        xferLog.push_back(memReq);
                        if (memReq.wen)
                                memImg[memReq.addr] = memReq.store;
                        waitLeft = $unsigned($random(seed)) % 4;
                end
                else if (waitLeft > 0 && (memReq.ren || memReq.wen))
                        waitLeft--;
                #1;
                memRsp.waitMem = (waitLeft > 0);
                memRsp.load = memWord(memReq.addr);
        end

        initial
        begin
                rstN = 1'b0;
                cpuReq = '0;
                memRsp = '0;
                repeat (5) @(posedge clk);
                #1;
                rstN = 1'b1;

                access("cold load", 1'b0, addrA, 32'h0, 2);
                checkXfer("cold load", 0, 1'b0, addrA, 32'h0);
                checkXfer("cold load", 1, 1'b0, addrA + 4, 32'h0);
                access("resident word", 1'b0, addrA + 4, 32'h0, 0);
                // second tag goes to way 1
                access("other way", 1'b0, addrB, 32'h0, 2);
                access("other way word1", 1'b0, addrB + 4, 32'h0, 0);

                access("store A0", 1'b1, addrA, 32'h1111_a0a0, 0);
                access("store A1", 1'b1, addrA + 4, 32'h2222_a1a1, 0);
                access("store B0", 1'b1, addrB, 32'h3333_b0b0, 0);
                access("store B1", 1'b1, addrB + 4, 32'h4444_b1b1, 0);
                access("reload A0", 1'b0, addrA, 32'h0, 0);
                access("reload A1", 1'b0, addrA + 4, 32'h0, 0);
                // B touched last, so dirty A is the victim
                access("reload B0", 1'b0, addrB, 32'h0, 0);
                access("reload B1", 1'b0, addrB + 4, 32'h0, 0);

                access("evict A", 1'b0, addrC, 32'h0, 4);
                checkXfer("evict A", 0, 1'b1, addrA, 32'h1111_a0a0);
                checkXfer("evict A", 1, 1'b1, addrA + 4, 32'h2222_a1a1);
                checkXfer("evict A", 2, 1'b0, addrC, 32'h0);
                checkXfer("evict A", 3, 1'b0, addrC + 4, 32'h0);
                access("evict B", 1'b0, addrA, 32'h0, 4);
                checkXfer("evict B", 0, 1'b1, addrB, 32'h3333_b0b0);
                checkXfer("evict B", 1, 1'b1, addrB + 4, 32'h4444_b1b1);
                checkXfer("evict B", 2, 1'b0, addrA, 32'h0);
                checkXfer("evict B", 3, 1'b0, addrA + 4, 32'h0);
                access("refetched A1", 1'b0, addrA + 4, 32'h0, 0);

                access("store C1", 1'b1, addrC + 4, 32'h5555_c1c1, 0);
                access("store D0", 1'b1, addrD, 32'h6666_d0d0, 2);

                // halt walks set 2 way 0 (C) before set 5 way 0 (D)
                @(posedge clk);
                #1;
                xferLog.delete();
                cpuReq.halt = 1'b1;
                waitFlushed();
                checkValue("flush memory words", 4, xferLog.size());
                checkXfer("flush", 0, 1'b1, addrC, fillWord(addrC));
                checkXfer("flush", 1, 1'b1, addrC + 4, 32'h5555_c1c1);
                checkXfer("flush", 2, 1'b1, addrD, 32'h6666_d0d0);
                checkXfer("flush", 3, 1'b1, addrD + 4, fillWord(addrD + 4));
                repeat (8)
                begin
                        @(negedge clk);
                        checkValue("quiet after flush", 32'h0, {memReq.ren, memReq.wen});
                end
                foreach (refImg[a])
                        checkValue($sformatf("memory image %h", a), refImg[a], memWord(a));

                if (dut_i.sva_i.failCount != 0)
                begin
                        $display("a protocol assertion on the cache top level failed");
                        stopRun();
                end
                else
                begin
                        $display("TEST PASSED");
                        $finish;
                end
        end

endmodule

//--- test/dcache_sva.sv
// protocol checks bound into the cache top level; rstN is synchronous, active low
`timescale 1ns/1ps

module dcacheSva
(
        input logic clk,
        input logic rstN,
        input dcachePkg::cpuRspT cpuRsp,
        input dcachePkg::memReqT memReq
);

        // first edge has no history yet
        logic pastValid = 1'b0;
        int failCount = 0;

        always @(posedge clk)
                pastValid <= 1'b1;

        oneMemOp: assert property (@(posedge clk) disable iff (!rstN)
                !(memReq.ren && memReq.wen))
                else
                begin
                        failCount++;
                        $error("memory read and write requested together");
                end

        hitWithoutMem: assert property (@(posedge clk) disable iff (!rstN)
                cpuRsp.hit |-> !(memReq.ren || memReq.wen))
                else
                begin
                        failCount++;
                        $error("hit raised while a memory request is active");
                end

        // only reset may clear flushed
        flushedSticky: assert property (@(posedge clk)
                pastValid && $past(rstN) && $past(cpuRsp.flushed) |-> cpuRsp.flushed)
                else
                begin
                        failCount++;
                        $error("flushed fell without reset");
                end

        resetValues: assert property (@(posedge clk)
                pastValid && !$past(rstN) |->
                !cpuRsp.hit && !memReq.ren && !memReq.wen && !cpuRsp.flushed)
                else
                begin
                        failCount++;
                        $error("outputs not low in the cycle after reset");
                end

endmodule

//--- vlog.f
design/dcachePkg.sv
design/dcacheTagArray.sv
design/dcacheDataArray.sv
design/dcacheController.sv
design/dcache.sv
test/dcache_sva.sv
test/dcacheTb.sv
